//--- Makefile
# Verilator build and run of the CSR block testbench

VERILATOR ?= verilator
TOP       ?= tb_csr_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
		echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf $(BUILD_DIR)

//--- csr_counters.sv
/* Full 64-bit mcycle and minstret. A software write to one half replaces that half
   at the edge, while the other half still takes the incremented value. */
`timescale 1ns/1ns

module csr_counters (
	input  logic                clk,
	input  logic                rst_n,
	input  csr_pkg::csr_req_t   req,
	input  logic                instr_ret, // One pulse per retired instruction
	output csr_pkg::counter_t   ctr
);

	csr_pkg::counter_t ctr_next;

	always_comb begin
		ctr_next.mcycle   = ctr.mcycle + 64'd1;          // Free running
		ctr_next.minstret = ctr.minstret + 64'(instr_ret);

		// Write, set or clear acts on the value before the increment
		if (req.wen) begin
			case (req.addr)
				csr_pkg::mcycle:
					ctr_next.mcycle[31:0] =
						csr_pkg::csr_update(req.wtype, ctr.mcycle[31:0], req.wdata);
				csr_pkg::mcycleh:
					ctr_next.mcycle[63:32] =
						csr_pkg::csr_update(req.wtype, ctr.mcycle[63:32], req.wdata);
				csr_pkg::minstret:
					ctr_next.minstret[31:0] =
						csr_pkg::csr_update(req.wtype, ctr.minstret[31:0], req.wdata);
				csr_pkg::minstreth:
					ctr_next.minstret[63:32] =
						csr_pkg::csr_update(req.wtype, ctr.minstret[63:32], req.wdata);
				default: ; // Not a counter
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			ctr <= '0;
		else
			ctr <= ctr_next;
	end

endmodule

//--- csr_pkg.sv
/* CSR map, access request and register state types for an M-mode only RV32 hart.
   Only the CSRs listed here are decoded, and every other address is an illegal access. */
package csr_pkg;

	localparam int xlen = 32; // RV32 only

	typedef logic [11:0]     csr_addr_t;
	typedef logic [xlen-1:0] csr_data_t;

	// Access kinds of the CSR instructions, encoded as the core's decode stage drives them
	typedef enum logic [1:0] {
		write = 2'd0, // CSRRW
		set   = 2'd1, // CSRRS
		clear = 2'd2  // CSRRC
	} csr_wtype_t;

	// ------------------------------
	// Address map
	// ------------------------------
	localparam csr_addr_t mvendorid = 12'hf11; // Identity, read-only
	localparam csr_addr_t marchid   = 12'hf12;
	localparam csr_addr_t mimpid    = 12'hf13;
	localparam csr_addr_t mhartid   = 12'hf14;

	localparam csr_addr_t mstatus   = 12'h300; // Trap setup
	localparam csr_addr_t misa      = 12'h301;
	localparam csr_addr_t mie       = 12'h304;
	localparam csr_addr_t mtvec     = 12'h305;

	localparam csr_addr_t mscratch  = 12'h340; // Trap handling
	localparam csr_addr_t mepc      = 12'h341;
	localparam csr_addr_t mcause    = 12'h342;
	localparam csr_addr_t mtval     = 12'h343;
	localparam csr_addr_t mip       = 12'h344;

	localparam csr_addr_t mcycle    = 12'hb00; // Counters, low then high halves
	localparam csr_addr_t minstret  = 12'hb02;
	localparam csr_addr_t mcycleh   = 12'hb80;
	localparam csr_addr_t minstreth = 12'hb82;

	// Field masks
	localparam csr_data_t mtvec_align_mask = 32'hffff_f000; // 4 KiB base, so the vector needs no adder
	localparam csr_data_t mepc_mask        = 32'hffff_fffe; // No odd PCs
	localparam csr_data_t mie_zero_mask    = 32'h0000_f777; // Bits that always read 0

	localparam int mstatus_mie_bit  = 3;
	localparam int mstatus_mpie_bit = 7;
	localparam int mie_meie_bit     = 11; // Global gate over the per-IRQ enables

	// One CSR access from the core, strobes valid in the cycle they are high
	typedef struct packed {
		csr_addr_t  addr;
		csr_data_t  wdata;
		csr_wtype_t wtype;
		logic       wen;
		logic       ren;
	} csr_req_t;

	// Stored trap state, as seen by the read mux and the trap logic
	typedef struct packed {
		csr_data_t  mtvec;        // Already aligned
		csr_data_t  mepc;
		csr_data_t  mie;
		logic       mstatus_mie;
		logic       mstatus_mpie;
		logic       mcause_irq;   // Sign bit of mcause
		logic [4:0] mcause_code;
	} trap_csr_t;

	typedef struct packed {
		logic [63:0] mcycle;
		logic [63:0] minstret;
	} counter_t;

	// Write, set or clear applied to the whole old value
	function automatic csr_data_t csr_update(csr_wtype_t wtype, csr_data_t old, csr_data_t wdata);
		case (wtype)
			set:     return old | wdata;
			clear:   return old & ~wdata;
			default: return wdata;
		endcase
	endfunction

endpackage

//--- csr_read_decode.sv
/* Combinational read mux and address decode. Writes to misa, mip and mtval are accepted
   and ignored; writes to the identity registers raise access_error. */
`timescale 1ns/1ns

module csr_read_decode (
	input  csr_pkg::csr_req_t    req,
	input  csr_pkg::trap_csr_t   state,
	input  csr_pkg::csr_data_t   scratch,
	input  csr_pkg::counter_t    ctr,
	input  csr_pkg::csr_data_t   mip,
	output csr_pkg::csr_data_t   rdata,
	output logic                 access_error // To the trap logic as an instruction fault
);

	logic mapped;   // Address names an implemented CSR
	logic identity; // One of the read-only ID registers

	always_comb begin
		mapped   = 1'b1;
		identity = 1'b0;
		rdata    = '0;
		case (req.addr)
			// ------------------------------
			// Machine information
			// ------------------------------
			csr_pkg::misa: rdata = {
				2'h1,    // MXL, 32 bit
				4'd0,
				13'd0,   // Z..N
				1'b0,    // M, no
				3'd0,    // L..J
				1'b1,    // I base
				5'd0,    // H..D
				1'b0,    // C, no
				2'd0     // B, A
			};
			csr_pkg::mvendorid,
			csr_pkg::marchid,
			csr_pkg::mimpid,
			csr_pkg::mhartid: identity = 1'b1; // All read 0, single hart

			// ------------------------------
			// Trap setup and handling
			// ------------------------------
			csr_pkg::mstatus: begin
				rdata[12:11] = 2'b11; // MPP, always M mode
				rdata[csr_pkg::mstatus_mpie_bit] = state.mstatus_mpie;
				rdata[csr_pkg::mstatus_mie_bit]  = state.mstatus_mie;
			end
			csr_pkg::mie:      rdata = state.mie;
			csr_pkg::mtvec:    rdata = {state.mtvec[31:2], 2'h1}; // Mode 1, vectored
			csr_pkg::mscratch: rdata = scratch;
			csr_pkg::mepc:     rdata = state.mepc;
			csr_pkg::mcause:   rdata = {state.mcause_irq, 26'd0, state.mcause_code};
			csr_pkg::mtval:    rdata = '0; // Hardwired
			csr_pkg::mip:      rdata = mip;

			// Counters
			csr_pkg::mcycle:    rdata = ctr.mcycle[31:0];
			csr_pkg::mcycleh:   rdata = ctr.mcycle[63:32];
			csr_pkg::minstret:  rdata = ctr.minstret[31:0];
			csr_pkg::minstreth: rdata = ctr.minstret[63:32];

			default: mapped = 1'b0;
		endcase
	end

	assign access_error = ((req.wen || req.ren) && !mapped) || (req.wen && identity);

endmodule

//--- csr_top.sv
/* M-mode CSR block with trap control for a single-issue RV32 core.
   Trap entry is a valid/ready handshake; trap_exit is a one-cycle strobe. */
`timescale 1ns/1ns

module csr_top (
	input  logic                        clk,
	input  logic                        rst_n,
	input  csr_pkg::csr_req_t           req,
	output csr_pkg::csr_data_t          rdata,       // Same cycle as req
	input  trap_pkg::except_t           except,
	input  logic [31:0]                 epc,         // Saved into mepc on entry
	input  logic [trap_pkg::n_irq-1:0]  irq,
	output trap_pkg::trap_req_t         trap,
	input  logic                        trap_enter_rdy,
	input  logic                        trap_exit,
	output logic [31:0]                 mepc_out,    // mret target
	input  logic                        instr_ret
);

	csr_pkg::trap_csr_t trap_state;
	csr_pkg::csr_data_t scratch;
	csr_pkg::counter_t  ctr;
	csr_pkg::csr_data_t mip;
	logic               access_error;
	logic               enter;

	assign mepc_out = trap_state.mepc;

	csr_trap_regs u_trap_regs (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (req),
		.enter     (enter),
		.trap      (trap),
		.epc       (epc),
		.trap_exit (trap_exit),
		.state     (trap_state),
		.scratch   (scratch)
	);

	csr_counters u_counters (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (req),
		.instr_ret (instr_ret),
		.ctr       (ctr)
	);

	csr_read_decode u_read_decode (
		.req          (req),
		.state        (trap_state),
		.scratch      (scratch),
		.ctr          (ctr),
		.mip          (mip),
		.rdata        (rdata),
		.access_error (access_error)
	);

	trap_request u_trap_request (
		.clk            (clk),
		.rst_n          (rst_n),
		.except         (except),
		.access_error   (access_error),
		.irq            (irq),
		.state          (trap_state),
		.trap_enter_rdy (trap_enter_rdy),
		.trap_exit      (trap_exit),
		.trap           (trap),
		.enter          (enter),
		.mip            (mip)
	);

endmodule

//--- csr_trap_regs.sv
/* Trap CSRs with software writes and trap entry/exit updates. Entry and exit win over a
   write to mstatus, mepc or mcause in the same cycle; other registers still take the write. */
`timescale 1ns/1ns

module csr_trap_regs (
	input  logic                  clk,
	input  logic                  rst_n,
	input  csr_pkg::csr_req_t     req,
	input  logic                  enter,     // vld and rdy of the trap offer
	input  trap_pkg::trap_req_t   trap,
	input  logic [31:0]           epc,       // PC to save, from the core
	input  logic                  trap_exit, // mret strobe
	output csr_pkg::trap_csr_t    state,
	output csr_pkg::csr_data_t    scratch
);

	logic wr_mstatus, wr_mscratch, wr_mtvec, wr_mepc, wr_mie, wr_mcause;

	csr_pkg::csr_data_t mstatus_old, mstatus_new; // Only MIE and MPIE are live
	csr_pkg::csr_data_t mcause_old, mcause_new;

	// ------------------------------
	// Write decode
	// ------------------------------
	assign wr_mstatus  = req.wen && req.addr == csr_pkg::mstatus;
	assign wr_mscratch = req.wen && req.addr == csr_pkg::mscratch;
	assign wr_mtvec    = req.wen && req.addr == csr_pkg::mtvec;
	assign wr_mepc     = req.wen && req.addr == csr_pkg::mepc;
	assign wr_mie      = req.wen && req.addr == csr_pkg::mie;
	assign wr_mcause   = req.wen && req.addr == csr_pkg::mcause;

	// Present the packed fields as full words so set/clear see the real bit positions
	always_comb begin
		mstatus_old = '0;
		mstatus_old[csr_pkg::mstatus_mie_bit]  = state.mstatus_mie;
		mstatus_old[csr_pkg::mstatus_mpie_bit] = state.mstatus_mpie;
	end

	assign mstatus_new = csr_pkg::csr_update(req.wtype, mstatus_old, req.wdata);
	assign mcause_old  = {state.mcause_irq, 26'd0, state.mcause_code};
	assign mcause_new  = csr_pkg::csr_update(req.wtype, mcause_old, req.wdata);

	// ------------------------------
	// State
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= '0;
		end else begin
			// Two-level interrupt enable stack
			if (enter) begin
				state.mstatus_mpie <= state.mstatus_mie;
				state.mstatus_mie  <= 1'b0; // No nesting until the handler re-enables
			end else if (trap_exit) begin
				state.mstatus_mpie <= 1'b1;
				state.mstatus_mie  <= state.mstatus_mpie;
			end else if (wr_mstatus) begin
				state.mstatus_mpie <= mstatus_new[csr_pkg::mstatus_mpie_bit];
				state.mstatus_mie  <= mstatus_new[csr_pkg::mstatus_mie_bit];
			end

			if (enter)
				state.mepc <= epc & csr_pkg::mepc_mask;
			else if (wr_mepc)
				state.mepc <= csr_pkg::csr_update(req.wtype, state.mepc, req.wdata) & csr_pkg::mepc_mask;

			if (enter) begin
				state.mcause_irq  <= !trap.is_exception; // Sign bit set for interrupts
				state.mcause_code <= trap.cause;
			end else if (wr_mcause) begin
				state.mcause_irq  <= mcause_new[31];
				state.mcause_code <= mcause_new[4:0];
			end

			if (wr_mtvec) // Low bits dropped, mode is supplied on read
				state.mtvec <= csr_pkg::csr_update(req.wtype, state.mtvec, req.wdata)
					& csr_pkg::mtvec_align_mask;

			if (wr_mie)
				state.mie <= csr_pkg::csr_update(req.wtype, state.mie, req.wdata)
					& ~csr_pkg::mie_zero_mask;
		end
	end

	// Scratch word for the handler, no hardware meaning
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			scratch <= '0;
		else if (wr_mscratch)
			scratch <= csr_pkg::csr_update(req.wtype, scratch, req.wdata);
	end

endmodule

//--- files.f
+incdir+.
csr_pkg.sv
trap_pkg.sv
priority_encoder.sv
csr_trap_regs.sv
csr_counters.sv
csr_read_decode.sv
trap_request.sv
csr_top.sv
tb_csr_top.sv

//--- priority_encoder.sv
/* Lowest set bit wins; an empty request reads as index 0,
   so the user must qualify gnt with a separate any-bit check. */
`timescale 1ns/1ns

module priority_encoder #(
	parameter type req_t = logic [15:0] // Any packed vector or packed struct
) (
	input  req_t                              req,
	output logic [$clog2($bits(req_t))-1:0]   gnt
);

	// Scan down from the top so the lowest hit is the last write
	always_comb begin
		gnt = '0;
		for (int i = $bits(req_t) - 1; i >= 0; i--) begin
			if (req[i])
				gnt = ($bits(gnt))'(i);
		end
	end

endmodule

//--- tb_csr_model.svh
/* Cycle model of the CSR block, included inside the testbench module.
   State moves at each clock edge from the inputs that are driven in that cycle. */
`ifndef TB_CSR_MODEL_SVH
`define TB_CSR_MODEL_SVH

csr_pkg::csr_data_t m_scratch;
csr_pkg::csr_data_t m_mtvec;   // Stored aligned, mode added on read
csr_pkg::csr_data_t m_mepc;
csr_pkg::csr_data_t m_mie;
logic               m_status_mie;
logic               m_status_mpie;
logic               m_cause_irq;
trap_pkg::cause_t   m_cause;
logic               m_in_trap;
logic [15:0]        m_irq_q;   // IRQ lines one edge late
logic [63:0]        m_mcycle;
logic [63:0]        m_minstret;

task automatic model_reset();
	m_scratch     = '0;
	m_mtvec       = '0;
	m_mepc        = '0;
	m_mie         = '0;
	m_status_mie  = 1'b0;
	m_status_mpie = 1'b0;
	m_cause_irq   = 1'b0;
	m_cause       = '0;
	m_in_trap     = 1'b0;
	m_irq_q       = '0;
	m_mcycle      = '0;
	m_minstret    = '0;
endtask

// Write, set or clear of a CSR instruction
function automatic csr_pkg::csr_data_t apply_op(csr_pkg::csr_wtype_t k,
		csr_pkg::csr_data_t old, csr_pkg::csr_data_t d);
	if (k == csr_pkg::set)
		return old | d;
	if (k == csr_pkg::clear)
		return old & ~d;
	return d;
endfunction

function automatic int lowest_set(logic [15:0] v);
	for (int i = 0; i < 16; i++)
		if (v[i])
			return i;
	return -1; // Empty
endfunction

function automatic logic is_identity(csr_pkg::csr_addr_t a);
	return a inside {csr_pkg::mvendorid, csr_pkg::marchid, csr_pkg::mimpid, csr_pkg::mhartid};
endfunction

function automatic logic is_mapped(csr_pkg::csr_addr_t a);
	return is_identity(a) || a inside {csr_pkg::misa, csr_pkg::mstatus, csr_pkg::mie,
		csr_pkg::mtvec, csr_pkg::mscratch, csr_pkg::mepc, csr_pkg::mcause, csr_pkg::mtval,
		csr_pkg::mip, csr_pkg::mcycle, csr_pkg::mcycleh, csr_pkg::minstret,
		csr_pkg::minstreth};
endfunction

// Illegal CSR access of the current request
function automatic logic bad_access();
	return ((req.wen || req.ren) && !is_mapped(req.addr)) || (req.wen && is_identity(req.addr));
endfunction

function automatic csr_pkg::csr_data_t model_read(csr_pkg::csr_addr_t a);
	case (a)
		csr_pkg::misa:      return 32'h4000_0100; // MXL 32, I only
		csr_pkg::mstatus:   return 32'h1800 | {24'd0, m_status_mpie, 3'd0, m_status_mie, 3'd0};
		csr_pkg::mie:       return m_mie;
		csr_pkg::mtvec:     return m_mtvec | 32'd1; // Vectored
		csr_pkg::mscratch:  return m_scratch;
		csr_pkg::mepc:      return m_mepc;
		csr_pkg::mcause:    return {m_cause_irq, 26'd0, m_cause};
		csr_pkg::mip:       return {m_irq_q, 4'd0, |m_irq_q, 11'd0};
		csr_pkg::mcycle:    return m_mcycle[31:0];
		csr_pkg::mcycleh:   return m_mcycle[63:32];
		csr_pkg::minstret:  return m_minstret[31:0];
		csr_pkg::minstreth: return m_minstret[63:32];
		default:            return '0; // Identity, mtval and unmapped
	endcase
endfunction

// Offer seen by the core in the current cycle
function automatic trap_pkg::trap_req_t model_trap();
	trap_pkg::trap_req_t t;
	logic [15:0]         ex;
	logic [15:0]         pend;
	t     = '0;
	ex    = except;
	ex[1] = ex[1] || bad_access(); // Bad CSR access is an instruction fault
	pend  = m_irq_q & m_mie[31:16] & {16{m_mie[csr_pkg::mie_meie_bit]}};
	if (ex != '0 && !m_in_trap) begin
		t.vld          = 1'b1;
		t.is_exception = 1'b1;
		t.cause        = 5'(lowest_set(ex));
	end else if (pend != '0 && m_status_mie) begin
		t.vld   = 1'b1;
		t.cause = 5'(trap_pkg::irq_cause_base + lowest_set(pend));
	end
	t.addr = m_mtvec + 32'(t.cause) * 32'd4;
	return t;
endfunction

// Effects of the coming rising edge
task automatic model_clock();
	trap_pkg::trap_req_t t;
	logic                enter;
	logic [31:0]         st;
	logic [31:0]         cw;
	logic [63:0]         cyc;
	logic [63:0]         ret;
	t     = model_trap();
	enter = t.vld && trap_enter_rdy;
	st    = apply_op(req.wtype, {24'd0, m_status_mpie, 3'd0, m_status_mie, 3'd0}, req.wdata);
	cw    = apply_op(req.wtype, {m_cause_irq, 26'd0, m_cause}, req.wdata);
	cyc   = m_mcycle + 64'd1;
	ret   = m_minstret + {63'd0, instr_ret};
	if (req.wen) begin
		case (req.addr)
			csr_pkg::mscratch: m_scratch = apply_op(req.wtype, m_scratch, req.wdata);
			csr_pkg::mtvec:
				m_mtvec = apply_op(req.wtype, m_mtvec, req.wdata) & csr_pkg::mtvec_align_mask;
			csr_pkg::mie:
				m_mie = apply_op(req.wtype, m_mie, req.wdata) & ~csr_pkg::mie_zero_mask;
			csr_pkg::mepc:
				if (!enter)
					m_mepc = apply_op(req.wtype, m_mepc, req.wdata) & csr_pkg::mepc_mask;
			csr_pkg::mcause:
				if (!enter) begin
					m_cause_irq = cw[31];
					m_cause     = cw[4:0];
				end
			csr_pkg::mstatus:
				if (!enter && !trap_exit) begin // Entry and exit own the enable stack
					m_status_mie  = st[3];
					m_status_mpie = st[7];
				end
			csr_pkg::mcycle:    cyc[31:0]  = apply_op(req.wtype, m_mcycle[31:0], req.wdata);
			csr_pkg::mcycleh:   cyc[63:32] = apply_op(req.wtype, m_mcycle[63:32], req.wdata);
			csr_pkg::minstret:  ret[31:0]  = apply_op(req.wtype, m_minstret[31:0], req.wdata);
			csr_pkg::minstreth: ret[63:32] = apply_op(req.wtype, m_minstret[63:32], req.wdata);
			default: ;
		endcase
	end
	if (enter) begin
		m_mepc        = epc & csr_pkg::mepc_mask;
		m_cause       = t.cause;
		m_cause_irq   = !t.is_exception;
		m_status_mpie = m_status_mie;
		m_status_mie  = 1'b0;
	end else if (trap_exit) begin
		m_status_mie  = m_status_mpie;
		m_status_mpie = 1'b1;
	end
	if (trap_exit)
		m_in_trap = 1'b0;
	else if (enter)
		m_in_trap = 1'b1;
	m_mcycle   = cyc;
	m_minstret = ret;
	m_irq_q    = irq;
endtask

`endif

//--- tb_csr_top.sv
/* Random testbench for csr_top against a cycle model. Inputs change 5 ns after
   each rising edge and every output is checked at the falling edge. */
`timescale 1ns/1ns

module tb_csr_top;

	localparam int n_rw        = 60; // Write and read-back pairs
	localparam int n_ctr       = 40;
	localparam int n_exc       = 80;
	localparam int n_irq_steps = 80;
	localparam int cycle_limit = 8 + 2 * n_rw + 2 * n_ctr + n_exc + n_irq_steps + 80;

	logic                       clk;
	logic                       rst_n;
	csr_pkg::csr_req_t          req;
	csr_pkg::csr_data_t         rdata;
	trap_pkg::except_t          except;
	logic [31:0]                epc;
	logic [trap_pkg::n_irq-1:0] irq;
	trap_pkg::trap_req_t        trap;
	logic                       trap_enter_rdy;
	logic                       trap_exit;
	logic [31:0]                mepc_out;
	logic                       instr_ret;

	integer             seed = 32'h9f431c7b;
	int                 cycles = 0;
	csr_pkg::csr_data_t seen_rdata; // rdata at the last falling edge

	csr_pkg::csr_addr_t rw_addrs [4] = '{csr_pkg::mscratch, csr_pkg::mtvec, csr_pkg::mepc,
		csr_pkg::mie};
	csr_pkg::csr_addr_t ctr_addrs [8] = '{csr_pkg::mcycle, csr_pkg::mcycleh, csr_pkg::minstret,
		csr_pkg::minstreth, csr_pkg::mvendorid, csr_pkg::marchid, csr_pkg::mimpid,
		csr_pkg::mhartid};
	csr_pkg::csr_addr_t exc_addrs [4] = '{csr_pkg::mepc, csr_pkg::mcause, csr_pkg::mstatus,
		csr_pkg::mtvec};
	csr_pkg::csr_addr_t irq_addrs [4] = '{csr_pkg::mip, csr_pkg::mcause, csr_pkg::mstatus,
		csr_pkg::mie};

	`include "tb_csr_model.svh"

	csr_top uut (
		.clk            (clk),
		.rst_n          (rst_n),
		.req            (req),
		.rdata          (rdata),
		.except         (except),
		.epc            (epc),
		.irq            (irq),
		.trap           (trap),
		.trap_enter_rdy (trap_enter_rdy),
		.trap_exit      (trap_exit),
		.mepc_out       (mepc_out),
		.instr_ret      (instr_ret)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic abort_run(string why);
		$display("%s", why);
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit)
			abort_run($sformatf("Timeout: no end of test after %0d cycles", cycles));
	end

	// ------------------------------
	// Compare tasks
	// ------------------------------
	task automatic check_data(string name, csr_pkg::csr_data_t exp, csr_pkg::csr_data_t act);
		if (act !== exp)
			abort_run($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_trap(string name, trap_pkg::trap_req_t exp, trap_pkg::trap_req_t act);
		// Address and cause carry no meaning without vld
		if (exp.vld ? act !== exp : act.vld !== 1'b0)
			abort_run($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_ctr(string name, logic [63:0] exp, logic [63:0] act);
		if (act !== exp)
			abort_run($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
	endtask

	function automatic csr_pkg::csr_wtype_t kind_of(logic [1:0] k);
		if (k == 2'd1)
			return csr_pkg::set;
		if (k == 2'd2)
			return csr_pkg::clear;
		return csr_pkg::write;
	endfunction

	task automatic idle();
		req            = '0;
		except         = '0;
		trap_enter_rdy = 1'b0;
		trap_exit      = 1'b0;
		instr_ret      = 1'b0;
	endtask

	// Check everything at the falling edge, then take the rising edge in model and DUT
	task automatic step(string name);
		@(negedge clk);
		seen_rdata = rdata;
		check_data({name, " rdata"}, model_read(req.addr), rdata);
		check_trap({name, " trap"}, model_trap(), trap);
		check_data({name, " mepc_out"}, m_mepc, mepc_out);
		model_clock();
		@(posedge clk);
		#5;
	endtask

	initial begin
		logic [31:0]         r;
		logic [31:0]         r2;
		csr_pkg::csr_data_t  prev;
		csr_pkg::csr_data_t  wd;
		trap_pkg::trap_req_t fault;
		idle();
		irq   = '0;
		epc   = '0;
		rst_n = 1'b0;
		model_reset();
		repeat (8) @(posedge clk);
		#5;
		rst_n = 1'b1;

		// ------------------------------
		// Trap CSR read-back
		// ------------------------------
		for (int i = 0; i < n_rw; i++) begin
			r         = $random(seed);
			req.addr  = rw_addrs[r[1:0]];
			req.wtype = kind_of(r[3:2]);
			req.wdata = $random(seed);
			req.wen   = 1'b1;
			step("trap csr write");
			req.wen = 1'b0;
			req.ren = 1'b1;
			step("trap csr read");
			idle();
		end

		// ------------------------------
		// Counters and identity registers
		// ------------------------------
		req.ren  = 1'b1;
		req.addr = csr_pkg::mcycle;
		step("mcycle");
		for (int i = 0; i < 4; i++) begin
			prev = seen_rdata;
			step("mcycle");
			check_ctr("mcycle step", {32'd0, prev} + 64'd1, {32'd0, seen_rdata});
		end
		for (int i = 0; i < n_ctr; i++) begin
			r         = $random(seed);
			req.addr  = ctr_addrs[r[2:0]];
			instr_ret = r[3];
			if (r[4] && !r[2]) begin // Overwrite a counter half
				wd        = $random(seed);
				req.wen   = 1'b1;
				req.wtype = csr_pkg::write;
				req.wdata = wd;
				step("counter write");
				req.wen = 1'b0;
				step("counter read");
				check_data("counter write-back", wd, seen_rdata);
			end else begin
				step("counter read");
			end
		end
		idle();

		// Illegal accesses, offered as instruction faults
		for (int i = 0; i < 6; i++) begin
			r        = $random(seed);
			req.addr = r[11:0];
			while (is_mapped(req.addr))
				req.addr = req.addr + 12'd1;
			req.ren = r[12];
			req.wen = !r[12];
			if (i == 5) begin
				req.addr = csr_pkg::mhartid;
				req.wen  = 1'b1;
			end
			step("illegal access");
			fault.vld          = 1'b1;
			fault.addr         = m_mtvec + 32'd4;
			fault.is_exception = 1'b1;
			fault.cause        = 5'd1;
			check_trap("illegal access fault", fault, trap);
		end

		// ------------------------------
		// Exceptions and trap entry/exit
		// ------------------------------
		idle();
		req.wen   = 1'b1;
		req.addr  = csr_pkg::mstatus;
		req.wtype = csr_pkg::set;
		req.wdata = 32'h8; // MIE on
		step("mstatus enable");
		for (int i = 0; i < n_exc; i++) begin
			r              = $random(seed);
			except         = r[20] ? trap_pkg::except_t'(r[15:0]) : '0;
			epc            = $random(seed);
			trap_enter_rdy = r[21];
			trap_exit      = r[22] && r[23] && !r[21]; // Never on an entry edge
			req            = '0;
			req.ren        = 1'b1;
			req.addr       = exc_addrs[r[25:24]];
			if (r[26] && r[27]) begin // Handler flips the enables now and then
				req.wen   = 1'b1;
				req.addr  = csr_pkg::mstatus;
				req.wtype = kind_of(r[29:28]);
				req.wdata = $random(seed);
			end
			step("exception");
		end

		// ------------------------------
		// Interrupts
		// ------------------------------
		idle();
		for (int i = 0; i < n_irq_steps; i++) begin
			r              = $random(seed);
			r2             = $random(seed);
			irq            = r[4] ? r2[15:0] : '0;
			trap_enter_rdy = r[8];
			trap_exit      = r[9] && r[10] && !r[8];
			req            = '0;
			if (r[7:5] == 3'd0) begin
				req.wen   = 1'b1;
				req.addr  = csr_pkg::mie;
				req.wtype = csr_pkg::write;
				req.wdata = $random(seed);
			end else if (r[7:5] == 3'd1) begin
				req.wen   = 1'b1;
				req.addr  = csr_pkg::mstatus;
				req.wtype = kind_of(r[12:11]);
				req.wdata = 32'h8;
			end else begin
				req.ren  = 1'b1;
				req.addr = irq_addrs[r[14:13]];
			end
			step("interrupt");
		end
		idle();
		step("final");

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

//--- trap_pkg.sv
/* Exception and trap request types. The exception index is also the mcause code,
   so lower indices take priority over higher ones. */
package trap_pkg;

	localparam int n_irq          = 16; // External IRQ lines, mapped to mip[31:16]
	localparam int n_except       = 16; // Width of the exception vector
	localparam int irq_cause_base = 16; // Cause of IRQ 0

	typedef logic [4:0] cause_t;

	// One flag per synchronous exception, LSB is index 0
	typedef struct packed {
		logic [3:0] rsvd_hi;          // 15:12
		logic       ecall;            // 11
		logic [2:0] rsvd_priv;        // 10:8, no S or U mode calls
		logic       store_fault;      // 7
		logic       store_misaligned; // 6
		logic       load_fault;       // 5
		logic       load_misaligned;  // 4
		logic       breakpoint;       // 3
		logic       instr_invalid;    // 2
		logic       instr_fault;      // 1, also raised on illegal CSR access
		logic       instr_misaligned; // 0
	} except_t;

	// Trap offer to the core, held while vld is high and rdy is low
	typedef struct packed {
		logic        vld;
		logic [31:0] addr;         // Absolute vector target
		logic        is_exception;
		cause_t      cause;
	} trap_req_t;

endpackage

//--- trap_request.sv
/* Builds the trap offer from exceptions and registered IRQs. IRQs are seen one cycle late,
   exceptions are blocked while in a trap, and interrupts are gated by mstatus MIE. */
`timescale 1ns/1ns

module trap_request (
	input  logic                        clk,
	input  logic                        rst_n,
	input  trap_pkg::except_t           except,
	input  logic                        access_error,
	input  logic [trap_pkg::n_irq-1:0]  irq,
	input  csr_pkg::trap_csr_t          state,
	input  logic                        trap_enter_rdy,
	input  logic                        trap_exit,
	output trap_pkg::trap_req_t         trap,
	output logic                        enter,
	output csr_pkg::csr_data_t          mip
);

	logic [trap_pkg::n_irq-1:0] irq_q;
	logic                       in_trap;  // Set from entry until mret

	trap_pkg::except_t                    except_req;
	logic [$clog2(trap_pkg::n_except)-1:0] except_num;
	logic                                 except_any;

	csr_pkg::csr_data_t irq_pend; // Enabled pending IRQs, at their mip positions
	trap_pkg::cause_t   irq_num;  // Index in irq_pend is already the cause code
	logic               irq_any;

	// ------------------------------
	// IRQ sampling and mip
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			irq_q <= '0;
		else
			irq_q <= irq;
	end

	// Per-IRQ status up top, plus the external pending summary in MEIP
	assign mip = (csr_pkg::csr_data_t'(irq_q) << trap_pkg::irq_cause_base)
		| (csr_pkg::csr_data_t'(|irq_q) << csr_pkg::mie_meie_bit);

	// MEIP itself is information only and never traps
	assign irq_pend = (csr_pkg::csr_data_t'(irq_q) << trap_pkg::irq_cause_base)
		& state.mie & {32{state.mie[csr_pkg::mie_meie_bit]}};
	assign irq_any  = |irq_pend && state.mstatus_mie;

	// ------------------------------
	// Exception selection
	// ------------------------------
	always_comb begin
		except_req = except;
		except_req.instr_fault = except.instr_fault || access_error; // Bad CSR access
	end

	assign except_any = |except_req && !in_trap;

	priority_encoder #(
		.req_t (trap_pkg::except_t)
	) u_except_pe (
		.req (except_req),
		.gnt (except_num)
	);

	priority_encoder #(
		.req_t (csr_pkg::csr_data_t)
	) u_irq_pe (
		.req (irq_pend),
		.gnt (irq_num)
	);

	// Offer; an exception that goes away drops vld again
	always_comb begin
		trap.vld          = except_any || irq_any;
		trap.is_exception = except_any;
		trap.cause        = except_any ? trap_pkg::cause_t'(except_num) : irq_num;
		trap.addr         = state.mtvec | (32'(trap.cause) << 2); // mtvec is 4 KiB aligned
	end

	assign enter = trap.vld && trap_enter_rdy;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			in_trap <= 1'b0;
		else
			in_trap <= (in_trap || enter) && !trap_exit;
	end

endmodule
